/* project.f */
common/mext_pkg.sv
src/mext_decode.sv
muldiv/mext_mul.sv
muldiv/mext_div.sv
src/mext_result.sv
src/mext_unit.sv
tests/clk_gen.sv
tests/mext_tb.sv

/* Makefile */
# Verilator build and run for the M extension unit

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f project.f --top-module mext_tb -o mext_sim

run: compile
	./obj_dir/mext_sim | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tests/mext_tb.sv */
//////////////////////////////////////////////////////////////////////
// table-driven testbench for the M extension unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mext_tb
    import mext_pkg::*;
;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // kind 0 is an M word, 1 a wrong opcode, 2 a wrong funct7
    typedef struct packed {
        logic [1:0] kind;
        mext_op_e   op;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       force_ops;
        word_t      a;
        word_t      b;
    } entry_s;

    logic              aclk;
    logic              aresetn;
    logic              m_valid;
    logic              m_ready;
    inst_t             m_instbus;
    reg_addr_t         m_rs1_addr;
    reg_addr_t         m_rs2_addr;
    word_t             m_rs1_val;
    word_t             m_rs2_val;
    logic              m_rd_wr;
    reg_addr_t         m_rd_addr;
    word_t             m_rd_val;
    logic [XLEN/8-1:0] m_rd_strb;

    word_t  regs [0:31];
    entry_s table_q[$];
    integer seed = 60184;
    int     errors = 0;
    int     n_entries = 0;

    clk_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(16)) u_clk (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    mext_unit #(.XLEN(XLEN)) dut0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_instbus  (m_instbus),
        .m_rs1_addr (m_rs1_addr),
        .m_rs1_val  (m_rs1_val),
        .m_rs2_addr (m_rs2_addr),
        .m_rs2_val  (m_rs2_val),
        .m_rd_wr    (m_rd_wr),
        .m_rd_addr  (m_rd_addr),
        .m_rd_val   (m_rd_val),
        .m_rd_strb  (m_rd_strb)
    );

    // register file model answers the query in the same cycle
    assign m_rs1_val = regs[m_rs1_addr];
    assign m_rs2_val = regs[m_rs2_addr];

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_val(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_strb(input logic [XLEN/8-1:0] act);
        if (act !== '1) begin
            errors++;
            $display("[FAIL] %0t m_rd_strb expected %h actual %h", $time, {(XLEN/8){1'b1}}, act);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////////////////////////

    function automatic word_t expect_result(input mext_op_e op, input word_t a, input word_t b);
        logic [2*XLEN-1:0] ea;
        logic [2*XLEN-1:0] eb;
        logic [2*XLEN-1:0] p;
        logic              sgn;
        word_t             q;
        word_t             r;
        // extension per operand, then a plain modulo 2^64 product
        ea = (op == OP_MULH || op == OP_MULHSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        eb = (op == OP_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        p  = ea * eb;
        sgn = (op == OP_DIV) || (op == OP_REM);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        case (op)
            OP_MUL:                          return p[XLEN-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU:    return p[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU:                 return q;
            default:                         return r;
        endcase
    endfunction

    function automatic inst_t encode(input entry_s e);
        logic [6:0] opcode;
        logic [6:0] funct7;
        opcode = (e.kind == 2'd1) ? 7'b0010011 : OPCODE_OP;
        funct7 = (e.kind == 2'd2) ? 7'b0100000 : FUNCT7_MULDIV;
        return {funct7, e.rs2, e.rs1, 3'(e.op), e.rd, opcode};
    endfunction

    task automatic add_entry(input logic [1:0] kind, input mext_op_e op, input reg_addr_t rs1,
                             input reg_addr_t rs2, input reg_addr_t rd, input logic force_ops,
                             input word_t a, input word_t b);
        entry_s e;
        e = '{kind, op, rs1, rs2, rd, force_ops, a, b};
        table_q.push_back(e);
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus driving
    //////////////////////////////////////////////////////////////////////

    // model takes the reference result, x0 stays zero
    task automatic write_model(input reg_addr_t rd, input word_t val);
        if (rd != '0) begin
            regs[rd] = val;
        end
    endtask

    task automatic check_write(input reg_addr_t rd, input word_t exp);
        check_bit("m_rd_wr", 1'b1, m_rd_wr);
        check_addr("m_rd_addr", rd, m_rd_addr);
        check_val("m_rd_val", exp, m_rd_val);
        check_strb(m_rd_strb);
        write_model(rd, exp);
    endtask

    // drive a word and return at the edge that accepts it
    task automatic issue(input inst_t word);
        @(posedge aclk);
        m_valid   <= 1'b1;
        m_instbus <= word;
        @(negedge aclk);
        while (!m_ready) @(negedge aclk);
        @(posedge aclk);
    endtask

    task automatic run_entry(input entry_s e);
        word_t exp;
        if (e.force_ops) begin
            regs[e.rs1] = e.a;
            regs[e.rs2] = e.b;
        end
        exp = expect_result(e.op, regs[e.rs1], regs[e.rs2]);
        issue(encode(e));
        m_valid <= 1'b0;
        @(negedge aclk);
        check_addr("m_rs1_addr", e.rs1, m_rs1_addr);
        check_addr("m_rs2_addr", e.rs2, m_rs2_addr);
        if (e.kind != 2'd0) begin
            repeat (3) begin
                check_bit("m_rd_wr", 1'b0, m_rd_wr);
                check_bit("m_ready", 1'b1, m_ready);
                @(negedge aclk);
            end
        end else begin
            if (!e.op[2]) begin
                // multiply result right after the accepting edge
                check_write(e.rd, exp);
            end else begin
                check_bit("m_ready", 1'b0, m_ready);
                while (!m_rd_wr) @(negedge aclk);
                check_bit("m_ready", 1'b1, m_ready);
                check_write(e.rd, exp);
            end
            // write strobe lasts a single cycle
            @(negedge aclk);
            check_bit("m_rd_wr", 1'b0, m_rd_wr);
        end
    endtask

    // divide followed by a multiply held on the bus
    task automatic run_backpressure;
        entry_s dv;
        entry_s ml;
        word_t  exp_d;
        word_t  exp_m;
        dv = '{2'd0, OP_DIV, 5'd3, 5'd4, 5'd20, 1'b0, '0, '0};
        ml = '{2'd0, OP_MULHU, 5'd5, 5'd6, 5'd21, 1'b0, '0, '0};
        exp_d = expect_result(dv.op, regs[3], regs[4]);
        exp_m = expect_result(ml.op, regs[5], regs[6]);
        issue(encode(dv));
        m_instbus <= encode(ml);
        @(negedge aclk);
        while (!m_rd_wr) begin
            check_bit("m_ready", 1'b0, m_ready);
            @(negedge aclk);
        end
        check_write(dv.rd, exp_d);
        @(posedge aclk);
        m_valid <= 1'b0;
        @(negedge aclk);
        check_write(ml.rd, exp_m);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        m_valid   = 1'b0;
        m_instbus = '0;
        regs[0]   = '0;
        for (int i = 1; i < 32; i++) begin
            regs[i] = $random(seed);
        end

        // random multiplies and sign edges
        add_entry(0, OP_MUL,    1, 2, 7, 0, '0, '0);
        add_entry(0, OP_MULH,   2, 3, 8, 0, '0, '0);
        add_entry(0, OP_MULHSU, 4, 5, 9, 0, '0, '0);
        add_entry(0, OP_MULHU,  6, 1, 12, 0, '0, '0);
        add_entry(0, OP_MULH,   10, 11, 13, 1, 32'h8000_0000, 32'h8000_0000);
        add_entry(0, OP_MULHSU, 10, 11, 13, 1, 32'hffff_ffff, 32'hffff_ffff);
        add_entry(0, OP_MULHU,  10, 11, 13, 1, 32'hffff_ffff, 32'hffff_ffff);
        add_entry(0, OP_MUL,    10, 11, 13, 1, 32'hffff_ffff, 32'h8000_0001);
        // divides with mixed signs
        add_entry(0, OP_DIV,    1, 2, 14, 0, '0, '0);
        add_entry(0, OP_DIVU,   3, 4, 15, 0, '0, '0);
        add_entry(0, OP_REM,    5, 6, 16, 0, '0, '0);
        add_entry(0, OP_REMU,   2, 5, 17, 0, '0, '0);
        add_entry(0, OP_DIV,    10, 11, 18, 1, 32'hffff_fff9, 32'h0000_0002);
        add_entry(0, OP_REM,    10, 11, 18, 1, 32'h0000_0007, 32'hffff_fffe);
        add_entry(0, OP_REM,    10, 11, 18, 1, 32'hffff_fff9, 32'hffff_fffe);
        // zero divisor and signed overflow
        add_entry(0, OP_DIV,    10, 11, 19, 1, 32'h1234_5678, '0);
        add_entry(0, OP_DIVU,   10, 11, 19, 1, 32'h8765_4321, '0);
        add_entry(0, OP_REM,    10, 11, 19, 1, 32'hdead_beef, '0);
        add_entry(0, OP_REMU,   10, 11, 19, 1, 32'hcafe_f00d, '0);
        add_entry(0, OP_DIV,    10, 11, 19, 1, 32'h8000_0000, 32'hffff_ffff);
        add_entry(0, OP_REM,    10, 11, 19, 1, 32'h8000_0000, 32'hffff_ffff);
        // words for other units
        add_entry(1, OP_MUL,    1, 2, 22, 0, '0, '0);
        add_entry(2, OP_DIV,    3, 4, 23, 0, '0, '0);
        n_entries = table_q.size() + 2;

        wait (aresetn === 1'b1);
        @(negedge aclk);
        check_bit("m_ready", 1'b1, m_ready);
        check_bit("m_rd_wr", 1'b0, m_rd_wr);
        check_addr("m_rd_addr", '0, m_rd_addr);
        check_val("m_rd_val", '0, m_rd_val);

        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end
        run_backpressure();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (n_entries > 0);
        #((n_entries * (XLEN + 8) + 32) * 4);
        $display("run timed out before all table entries completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* tests/clk_gen.sv */
//////////////////////////////////////////////////////////////////////
// testbench clock and reset source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD_NS   = 4.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk    = 1'b0;
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
    end

    always #(PERIOD_NS / 2.0) aclk = ~aclk;

endmodule

/* src/mext_unit.sv */
//////////////////////////////////////////////////////////////////////
// M extension top: decode, multiplier, divider and write-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mext_unit
    import mext_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    // instruction bus
    input  logic              m_valid,
    output logic              m_ready,
    input  inst_t             m_instbus,
    // register query
    output reg_addr_t         m_rs1_addr,
    input  logic [XLEN-1:0]   m_rs1_val,
    output reg_addr_t         m_rs2_addr,
    input  logic [XLEN-1:0]   m_rs2_val,
    // register write
    output logic              m_rd_wr,
    output reg_addr_t         m_rd_addr,
    output logic [XLEN-1:0]   m_rd_val,
    output logic [XLEN/8-1:0] m_rd_strb
);

    mext_ctrl_s      ctrl;
    logic            xfer;
    logic            mul_take;
    logic            div_start;
    logic [XLEN-1:0] product;
    logic            div_busy;
    logic            div_done;
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;
    mext_op_e        div_op;
    reg_addr_t       div_rd;

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    assign m_ready   = ~div_busy;
    assign xfer      = m_valid & m_ready;
    assign mul_take  = xfer & ctrl.is_m & ~ctrl.is_div;
    assign div_start = xfer & ctrl.is_m & ctrl.is_div;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    mext_decode u_decode (
        .inst     (m_instbus),
        .rs1_addr (m_rs1_addr),
        .rs2_addr (m_rs2_addr),
        .ctrl     (ctrl)
    );

    mext_mul #(.XLEN(XLEN)) u_mul (
        .op      (ctrl.op),
        .rs1_val (m_rs1_val),
        .rs2_val (m_rs2_val),
        .product (product)
    );

    mext_div #(.XLEN(XLEN)) u_div (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .start    (div_start),
        .ctrl     (ctrl),
        .dividend (m_rs1_val),
        .divisor  (m_rs2_val),
        .busy     (div_busy),
        .done     (div_done),
        .quot     (quot),
        .rem      (rem),
        .op_r     (div_op),
        .rd_r     (div_rd)
    );

    mext_result #(.XLEN(XLEN)) u_result (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .mul_take (mul_take),
        .mul_ctrl (ctrl),
        .product  (product),
        .div_done (div_done),
        .div_op   (div_op),
        .div_rd   (div_rd),
        .quot     (quot),
        .rem      (rem),
        .rd_wr    (m_rd_wr),
        .rd_addr  (m_rd_addr),
        .rd_val   (m_rd_val),
        .rd_strb  (m_rd_strb)
    );

endmodule

/* src/mext_result.sv */
//////////////////////////////////////////////////////////////////////
// write-back register for the multiply/divide unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mext_result
    import mext_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              mul_take,
    input  mext_ctrl_s        mul_ctrl,
    input  logic [XLEN-1:0]   product,
    input  logic              div_done,
    input  mext_op_e          div_op,
    input  reg_addr_t         div_rd,
    input  logic [XLEN-1:0]   quot,
    input  logic [XLEN-1:0]   rem,
    output logic              rd_wr,
    output reg_addr_t         rd_addr,
    output logic [XLEN-1:0]   rd_val,
    output logic [XLEN/8-1:0] rd_strb
);

    logic            div_is_rem;
    logic [XLEN-1:0] div_val;

    assign div_is_rem = (div_op == OP_REM) || (div_op == OP_REMU);
    assign div_val    = div_is_rem ? rem : quot;

    // a multiply and a divide never finish together, one item in flight
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_wr   <= 1'b0;
            rd_addr <= '0;
            rd_val  <= '0;
        end else begin
            rd_wr <= mul_take | div_done;
            if (div_done) begin
                rd_addr <= div_rd;
                rd_val  <= div_val;
            end else if (mul_take) begin
                rd_addr <= mul_ctrl.rd;
                rd_val  <= product;
            end
        end
    end

    // full-word writes only
    assign rd_strb = '1;

endmodule

/* muldiv/mext_div.sv */
//////////////////////////////////////////////////////////////////////
// iterative restoring divider for DIV, DIVU, REM and REMU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mext_div
    import mext_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            start,
    input  mext_ctrl_s      ctrl,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] quot,
    output logic [XLEN-1:0] rem,
    output mext_op_e        op_r,
    output reg_addr_t       rd_r
);

    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_FIX
    } div_state_e;

    div_state_e       state;
    logic [CNT_W-1:0] cnt;

    // working registers
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] d;
    logic [XLEN-1:0] dvd_r;
    logic            neg_q;
    logic            neg_r;
    logic            div_zero;
    logic            ovf;

    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] a_abs;
    logic [XLEN-1:0] b_abs;
    logic [XLEN:0]   r_shift;
    logic [XLEN:0]   diff;

    //////////////////////////////////////////////////////////////////////
    // operand preparation
    //////////////////////////////////////////////////////////////////////

    assign a_neg = ctrl.div_signed & dividend[XLEN-1];
    assign b_neg = ctrl.div_signed & divisor[XLEN-1];
    assign a_abs = a_neg ? -dividend : dividend;
    assign b_abs = b_neg ? -divisor : divisor;

    // one restoring step: shift in the next dividend bit and try a subtract
    assign r_shift = {r, q[XLEN-1]};
    assign diff    = r_shift - {1'b0, d};

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_RUN;
                        cnt   <= '0;
                    end
                end
                S_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(XLEN-1)) begin
                        state <= S_FIX;
                    end
                end
                default: begin
                    // results are taken by write-back during this cycle
                    state <= S_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (state == S_IDLE && start) begin
            q        <= a_abs;
            r        <= '0;
            d        <= b_abs;
            dvd_r    <= dividend;
            neg_q    <= a_neg ^ b_neg;
            neg_r    <= a_neg;
            div_zero <= (divisor == '0);
            ovf      <= ctrl.div_signed
                        && (dividend == {1'b1, {(XLEN-1){1'b0}}})
                        && (divisor == '1);
            op_r     <= ctrl.op;
            rd_r     <= ctrl.rd;
        end else if (state == S_RUN) begin
            if (!diff[XLEN]) begin
                r <= diff[XLEN-1:0];
                q <= {q[XLEN-2:0], 1'b1};
            end else begin
                r <= r_shift[XLEN-1:0];
                q <= {q[XLEN-2:0], 1'b0};
            end
        end
    end

    // sign restore and special cases, valid while done is high
    always_comb begin
        if (div_zero) begin
            quot = '1;
            rem  = dvd_r;
        end else if (ovf) begin
            quot = dvd_r;
            rem  = '0;
        end else begin
            quot = neg_q ? -q : q;
            rem  = neg_r ? -r : r;
        end
    end

    assign busy = (state != S_IDLE);
    assign done = (state == S_FIX);

endmodule

/* muldiv/mext_mul.sv */
//////////////////////////////////////////////////////////////////////
// single-cycle multiplier for MUL, MULH, MULHSU and MULHU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mext_mul
    import mext_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  mext_op_e        op,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    output logic [XLEN-1:0] product
);

    logic                     rs1_signed;
    logic                     rs2_signed;
    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] prod;

    // operand signedness per op, MUL does not care as only the low half is kept
    assign rs1_signed = (op == OP_MULH) || (op == OP_MULHSU);
    assign rs2_signed = (op == OP_MULH);

    // one extra bit turns every case into a signed multiply
    assign a_ext = {rs1_signed & rs1_val[XLEN-1], rs1_val};
    assign b_ext = {rs2_signed & rs2_val[XLEN-1], rs2_val};

    // shared multiplier for all four variants
    assign prod = a_ext * b_ext;

    always_comb begin
        if (op == OP_MUL) begin
            product = prod[XLEN-1:0];
        end else begin
            // high half
            product = prod[2*XLEN-1:XLEN];
        end
    end

endmodule

/* src/mext_decode.sv */
//////////////////////////////////////////////////////////////////////
// instruction decoder for the multiply/divide unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mext_decode
    import mext_pkg::*;
(
    input  inst_t      inst,
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    output mext_ctrl_s ctrl
);

    //////////////////////////////////////////////////////////////////////
    // field extraction
    //////////////////////////////////////////////////////////////////////

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    reg_addr_t           rd;
    mext_op_e            op;

    assign opcode = inst[OPCODE_POS +: OPCODE_W];
    assign funct3 = inst[FUNCT3_POS +: FUNCT3_W];
    assign funct7 = inst[FUNCT7_POS +: FUNCT7_W];
    assign rd     = inst[RD_POS +: REG_W];

    // register query addresses go out regardless of the class
    assign rs1_addr = inst[RS1_POS +: REG_W];
    assign rs2_addr = inst[RS2_POS +: REG_W];

    assign op = mext_op_e'(funct3);

    //////////////////////////////////////////////////////////////////////
    // classification
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl.op     = op;
        ctrl.rd     = rd;
        ctrl.is_m   = (opcode == OPCODE_OP) && (funct7 == FUNCT7_MULDIV);
        // upper half of the funct3 space is divide/remainder
        ctrl.is_div = funct3[2];
        ctrl.div_signed = (op == OP_DIV) || (op == OP_REM);
    end

endmodule

/* common/mext_pkg.sv */
//////////////////////////////////////////////////////////////////////
// M extension shared types: instruction fields, op codes, control
//////////////////////////////////////////////////////////////////////

package mext_pkg;

    //////////////////////////////////////////////////////////////////////
    // instruction field positions and widths
    //////////////////////////////////////////////////////////////////////

    localparam int INST_W     = 32;
    localparam int REG_W      = 5;

    localparam int OPCODE_POS = 0;
    localparam int OPCODE_W   = 7;
    localparam int RD_POS     = 7;
    localparam int FUNCT3_POS = 12;
    localparam int FUNCT3_W   = 3;
    localparam int RS1_POS    = 15;
    localparam int RS2_POS    = 20;
    localparam int FUNCT7_POS = 25;
    localparam int FUNCT7_W   = 7;

    // register-register arithmetic opcode
    localparam logic [OPCODE_W-1:0] OPCODE_OP     = 7'b0110011;
    // funct7 that selects multiply/divide within OP
    localparam logic [FUNCT7_W-1:0] FUNCT7_MULDIV = 7'b0000001;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [INST_W-1:0] inst_t;
    typedef logic [REG_W-1:0]  reg_addr_t;

    // funct3 encodings, bit 2 splits multiply from divide
    typedef enum logic [FUNCT3_W-1:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } mext_op_e;

    // decoded control, handed to execute and write-back
    typedef struct packed {
        mext_op_e  op;
        reg_addr_t rd;
        logic      is_m;
        logic      is_div;
        logic      div_signed;
    } mext_ctrl_s;

endpackage
